// ==== src.f ====
verilog/game_pkg.sv
verilog/board_rotate.sv
verilog/merge_engine.sv
verilog/tile_spawn.sv
verilog/move_counter.sv
verilog/move_fsm.sv
verilog/apb_board_regs.sv
verilog/game2048_top.sv
tests/game_checker.sv
tests/tb_game2048.sv

// ==== tests/game_cases.txt ====
// init row0 row1 row2 row3, cmd (dir 1:0, pos 5:2, prob 11:6),
// expected row0 row1 row2 row3, flags (bit 0 movable, bit 1 spawned), all hex
08421 00401 18000 00442 03c 00042 00002 00003 10023 3
10842 00041 00000 20004 162 18c00 10400 00001 28000 3
00c01 00041 00c01 30041 015 31062 00042 00000 00000 3
10403 00403 10400 004a0 1eb 00000 00000 00800 188a4 1
20c41 000c5 00000 00007 028 20c41 000c5 00000 00007 0
10441 08822 00000 00000 031 10441 08822 00000 00000 0
00842 08001 10420 29484 fcc 08043 00002 00042 000c5 3
08003 00003 00803 00003 003 00002 00000 00004 08804 3
00022 00002 00022 48002 051 48043 00003 00000 00000 1
10400 19060 00000 20c41 002 10400 19060 00000 20c41 0
003bd 00000 00000 00000 804 0003e 00000 00000 00000 3
00000 00000 00000 00000 01d 00000 00000 00000 00000 0
08420 18c63 00002 00821 026 10400 21000 10040 10800 3

// ==== tests/game_checker.sv ====
`timescale 1ns/1ns

module game_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  game_pkg::apb_addr_t  paddr,
    input  game_pkg::apb_data_t  prdata,
    input  logic                 pready,
    input  logic                 pslverr,
    input  logic                 final_phase,
    input  game_pkg::board_t     exp_board,
    input  game_pkg::apb_data_t  exp_status,
    output int                   check_count,
    output int                   error_count
);

    localparam int MOVE_CYCLES = 6;

    int   busy_cnt;
    logic model_busy;
    logic mapped;
    logic exp_err;
    logic cmd_write;

    initial begin
        check_count = 0;
        error_count = 0;
        busy_cnt    = 0;
    end

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        check_count = check_count + 1;
        if (exp !== got) begin
            error_count = error_count + 1;
            $display("Fail %s at paddr %h: expected %h, got %h", name, paddr, exp, got);
        end
    endtask

    // ***********************************************************
    // busy model, then checks on each completed transfer
    // ***********************************************************
    always @(negedge clk) begin
        if (reset) begin
            busy_cnt = 0;
        end else begin
            model_busy = (busy_cnt != 0);
            if (busy_cnt != 0) begin
                busy_cnt = busy_cnt - 1;
            end
            if (psel && penable) begin
                mapped    = (paddr <= game_pkg::ADDR_STATUS) && (paddr[1:0] == 2'b00);
                cmd_write = pwrite && (paddr == game_pkg::ADDR_CMD);
                exp_err   = !mapped || (cmd_write && model_busy);
                expect_value("pready", 32'd1, {31'b0, pready});
                expect_value("pslverr", {31'b0, exp_err}, {31'b0, pslverr});
                // accepted command starts a 6 cycle move
                if (cmd_write && !model_busy) begin
                    busy_cnt = MOVE_CYCLES;
                end
                if (!pwrite) begin
                    if (!mapped) begin
                        expect_value("prdata", 32'd0, prdata);
                    end else if (paddr == game_pkg::ADDR_STATUS) begin
                        if (model_busy) begin
                            expect_value("status busy", 32'd1, {31'b0, prdata[0]});
                        end else if (final_phase) begin
                            expect_value("prdata status", exp_status, prdata);
                        end
                    end else if (paddr < game_pkg::ADDR_CMD && final_phase) begin
                        expect_value("prdata row", game_pkg::apb_data_t'(
                            exp_board[paddr[3:2]*$bits(game_pkg::line_t)
                                      +: $bits(game_pkg::line_t)]), prdata);
                    end
                end
            end
        end
    end

endmodule

// ==== tests/tb_game2048.sv ====
`timescale 1ns/1ns

module tb_game2048;

    localparam int CLK_PERIOD = 4;
    localparam int WORDS      = 10;
    localparam int MAX_CASES  = 32;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    game_pkg::apb_addr_t  paddr;
    game_pkg::apb_data_t  pwdata;
    game_pkg::apb_data_t  prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 final_phase;
    logic                 cases_ready;
    game_pkg::board_t     exp_board;
    game_pkg::apb_data_t  exp_status;
    game_pkg::apb_data_t  rd_data;
    int                   check_count;
    int                   error_count;
    int                   num_cases;
    int                   moves;
    logic [31:0]          lcg_state;
    logic [31:0]          case_mem [0:WORDS*MAX_CASES-1];

    game2048_top DUT (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    game_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .final_phase (final_phase),
        .exp_board   (exp_board),
        .exp_status  (exp_status),
        .check_count (check_count),
        .error_count (error_count)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // 0 to 3 idle cycles before a transfer
    task automatic idle_gap();
        lcg_state = lcg_next(lcg_state);
        repeat (lcg_state[17:16]) begin
            @(posedge clk);
            #1;
        end
    endtask

    // ***********************************************************
    // APB master, called 1 ns after a rising edge
    // ***********************************************************
    task automatic apb_write(input game_pkg::apb_addr_t addr, input game_pkg::apb_data_t data);
        idle_gap();
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input game_pkg::apb_addr_t addr, output game_pkg::apb_data_t data);
        idle_gap();
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_case(input int idx);
        int base;
        logic [31:0] flags;
        base  = idx * WORDS;
        flags = case_mem[base+9];
        final_phase = 1'b0;
        exp_board = {case_mem[base+8][19:0], case_mem[base+7][19:0],
                     case_mem[base+6][19:0], case_mem[base+5][19:0]};
        if (flags[0]) begin
            moves = moves + 1;
        end
        exp_status = {moves[15:0], 13'b0, flags[1], flags[0], 1'b0};
        for (int r = 0; r < 4; r++) begin
            apb_write(game_pkg::apb_addr_t'(4*r), case_mem[base+r]);
        end
        apb_write(game_pkg::ADDR_CMD, case_mem[base+4]);
        // lands inside the move, must bounce
        apb_write(game_pkg::ADDR_CMD, case_mem[base+4] ^ 32'h0000_0fff);
        final_phase = 1'b1;
        do begin
            apb_read(game_pkg::ADDR_STATUS, rd_data);
        end while (rd_data[0]);
        for (int r = 0; r < 4; r++) begin
            apb_read(game_pkg::apb_addr_t'(4*r), rd_data);
        end
        final_phase = 1'b0;
    endtask

    initial begin
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        final_phase = 1'b0;
        cases_ready = 1'b0;
        exp_board   = '0;
        exp_status  = '0;
        moves       = 0;
        lcg_state   = 32'h4cc9;
        $readmemh("tests/game_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && !$isunknown(case_mem[num_cases*WORDS])) begin
            num_cases = num_cases + 1;
        end
        cases_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        // unmapped address
        apb_read(8'h20, rd_data);
        @(posedge clk);
        $display("cases %0d, checks %0d, errors %0d", num_cases, check_count, error_count);
        if (num_cases == 0) begin
            $display("no cases could be read from tests/game_cases.txt");
        end
        if (error_count == 0 && num_cases > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, 60 cycles per case plus reset
    initial begin
        wait (cases_ready === 1'b1);
        #(num_cases * 60 * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("timeout: the cases did not complete in the allowed time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verilog/apb_board_regs.sv ====
`timescale 1ns/1ns

module apb_board_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  game_pkg::apb_addr_t    paddr,
    input  game_pkg::apb_data_t    pwdata,
    input  logic                   busy,
    input  logic                   store,
    input  logic                   movable,
    input  logic                   spawned,
    input  game_pkg::move_count_t  move_count,
    input  game_pkg::board_t       new_board,
    output game_pkg::apb_data_t    prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   start,
    output game_pkg::board_t       board,
    output game_pkg::dir_t         dir,
    output game_pkg::pos_t         pos,
    output game_pkg::prob_t        prob
);

    logic                 access;
    logic                 wr;
    logic                 mapped;
    logic                 row_hit;
    logic                 cmd_hit;
    logic                 movable_q;
    logic                 spawned_q;
    game_pkg::line_idx_t  row_sel;

    // no wait states
    assign pready = 1'b1;

    assign access  = psel && penable;
    assign wr      = access && pwrite;
    assign row_sel = paddr[3:2];
    assign cmd_hit = (paddr == game_pkg::ADDR_CMD);

    // ***********************************************************
    // address decode and read mux
    // ***********************************************************
    always_comb begin
        prdata  = '0;
        mapped  = 1'b1;
        row_hit = 1'b0;
        case (paddr)
            game_pkg::ADDR_ROW0, game_pkg::ADDR_ROW1,
            game_pkg::ADDR_ROW2, game_pkg::ADDR_ROW3: begin
                row_hit = 1'b1;
                prdata  = game_pkg::apb_data_t'(
                    board[row_sel*$bits(game_pkg::line_t) +: $bits(game_pkg::line_t)]);
            end
            game_pkg::ADDR_CMD: begin
                prdata = game_pkg::apb_data_t'({prob, pos, dir});
            end
            game_pkg::ADDR_STATUS: begin
                prdata = {move_count, 13'b0, spawned_q, movable_q, busy};
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    // command while a move runs is rejected
    assign pslverr = access && (!mapped || (pwrite && cmd_hit && busy));
    assign start   = wr && cmd_hit && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            board     <= '0;
            dir       <= '0;
            pos       <= '0;
            prob      <= '0;
            movable_q <= 1'b0;
            spawned_q <= 1'b0;
        end else begin
            if (store) begin
                board     <= new_board;
                movable_q <= movable;
                spawned_q <= spawned;
            end else if (wr && row_hit && !busy) begin
                board[row_sel*$bits(game_pkg::line_t) +: $bits(game_pkg::line_t)] <=
                    pwdata[$bits(game_pkg::line_t)-1:0];
            end
            if (start) begin
                dir  <= pwdata[1:0];
                pos  <= pwdata[5:2];
                prob <= pwdata[11:6];
            end
        end
    end

endmodule

// ==== verilog/board_rotate.sv ====
`timescale 1ns/1ns

module board_rotate #(
    parameter bit inverse = 1'b0
) (
    input  game_pkg::board_t board_in,
    input  game_pkg::dir_t   dir,
    output game_pkg::board_t board_out
);

    // src is the board cell, dst the slot in line order
    always_comb begin
        int src;
        int dst;
        board_out = '0;
        for (int k = 0; k < game_pkg::NUM_LINES; k++) begin
            for (int j = 0; j < game_pkg::LINE_CELLS; j++) begin
                case (dir)
                    2'd0: src = 4*k + j;
                    2'd1: src = 4*j + k;
                    2'd2: src = 4*k + 3 - j;
                    default: src = 12 - 4*j + k;
                endcase
                dst = 4*k + j;
                if (inverse) begin
                    board_out[src*game_pkg::CELL_BITS +: game_pkg::CELL_BITS] =
                        board_in[dst*game_pkg::CELL_BITS +: game_pkg::CELL_BITS];
                end else begin
                    board_out[dst*game_pkg::CELL_BITS +: game_pkg::CELL_BITS] =
                        board_in[src*game_pkg::CELL_BITS +: game_pkg::CELL_BITS];
                end
            end
        end
    end

endmodule

// ==== verilog/game2048_top.sv ====
`timescale 1ns/1ns

module game2048_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  game_pkg::apb_addr_t   paddr,
    input  game_pkg::apb_data_t   pwdata,
    output game_pkg::apb_data_t   prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic                    start;
    logic                    busy;
    logic                    load;
    logic                    step;
    logic                    store;
    logic                    last_line;
    logic                    movable;
    logic                    spawned;
    game_pkg::board_t        board;
    game_pkg::board_t        rotated;
    game_pkg::board_t        work_board;
    game_pkg::board_t        restored;
    game_pkg::board_t        new_board;
    game_pkg::dir_t          dir;
    game_pkg::pos_t          pos;
    game_pkg::prob_t         prob;
    game_pkg::line_idx_t     line_idx;
    game_pkg::move_count_t   move_count;

    apb_board_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .busy       (busy),
        .store      (store),
        .movable    (movable),
        .spawned    (spawned),
        .move_count (move_count),
        .new_board  (new_board),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .board      (board),
        .dir        (dir),
        .pos        (pos),
        .prob       (prob)
    );

    move_fsm u_fsm (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .last_line (last_line),
        .busy      (busy),
        .load      (load),
        .step      (step),
        .store     (store)
    );

    move_counter u_counter (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .step       (step),
        .store      (store),
        .movable    (movable),
        .line_idx   (line_idx),
        .last_line  (last_line),
        .move_count (move_count)
    );

    // into line order for the merge
    board_rotate #(.inverse(1'b0)) u_rotate_fwd (
        .board_in  (board),
        .dir       (dir),
        .board_out (rotated)
    );

    merge_engine u_merge (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .step       (step),
        .line_idx   (line_idx),
        .rotated    (rotated),
        .work_board (work_board),
        .movable    (movable)
    );

    // back to board order for spawn and store
    board_rotate #(.inverse(1'b1)) u_rotate_inv (
        .board_in  (work_board),
        .dir       (dir),
        .board_out (restored)
    );

    tile_spawn u_spawn (
        .board_in  (restored),
        .pos       (pos),
        .prob      (prob),
        .movable   (movable),
        .new_board (new_board),
        .spawned   (spawned)
    );

endmodule

// ==== verilog/game_pkg.sv ====
package game_pkg;

    // ***********************************************************
    // board geometry
    // ***********************************************************
    localparam int CELL_BITS  = 5;
    localparam int LINE_CELLS = 4;
    localparam int NUM_LINES  = 4;

    // tile exponent, 0 is an empty cell
    typedef logic [CELL_BITS-1:0] cell_t;
    typedef logic [LINE_CELLS*CELL_BITS-1:0] line_t;
    // cell i at bits 5i+4:5i, row i/4, column i mod 4
    typedef logic [NUM_LINES*LINE_CELLS*CELL_BITS-1:0] board_t;

    // 0 left, 1 up, 2 right, 3 down
    typedef logic [1:0] dir_t;
    typedef logic [3:0] pos_t;
    typedef logic [5:0] prob_t;
    typedef logic [1:0] line_idx_t;
    typedef logic [15:0] move_count_t;

    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        MERGE,
        STORE
    } move_state_t;

    // ***********************************************************
    // register map
    // ***********************************************************
    localparam apb_addr_t ADDR_ROW0   = 8'h00;
    localparam apb_addr_t ADDR_ROW1   = 8'h04;
    localparam apb_addr_t ADDR_ROW2   = 8'h08;
    localparam apb_addr_t ADDR_ROW3   = 8'h0C;
    localparam apb_addr_t ADDR_CMD    = 8'h10;
    localparam apb_addr_t ADDR_STATUS = 8'h14;

    // new tile exponents
    localparam cell_t SPAWN_FOUR = 5'd2;
    localparam cell_t SPAWN_TWO  = 5'd1;

endpackage

// ==== verilog/merge_engine.sv ====
`timescale 1ns/1ns

module merge_engine (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic                 step,
    input  game_pkg::line_idx_t  line_idx,
    input  game_pkg::board_t     rotated,
    output game_pkg::board_t     work_board,
    output logic                 movable
);

    game_pkg::line_t cur_line;
    game_pkg::line_t merged_line;

    // ***********************************************************
    // slide toward position 0, then merge equal pairs once
    // ***********************************************************
    function automatic game_pkg::line_t merge_line(input game_pkg::line_t line_in);
        game_pkg::cell_t slid [game_pkg::LINE_CELLS+1];
        game_pkg::line_t line_out;
        int n;
        int k;
        bit skip;
        line_out = '0;
        n = 0;
        k = 0;
        skip = 1'b0;
        for (int i = 0; i <= game_pkg::LINE_CELLS; i++) begin
            slid[i] = '0;
        end
        for (int i = 0; i < game_pkg::LINE_CELLS; i++) begin
            if (line_in[i*game_pkg::CELL_BITS +: game_pkg::CELL_BITS] != '0) begin
                slid[n] = line_in[i*game_pkg::CELL_BITS +: game_pkg::CELL_BITS];
                n++;
            end
        end
        // trailing zero slot ends the last compare
        for (int i = 0; i < game_pkg::LINE_CELLS; i++) begin
            if (skip) begin
                skip = 1'b0;
            end else if (slid[i] != '0) begin
                if (slid[i] == slid[i+1]) begin
                    line_out[k*game_pkg::CELL_BITS +: game_pkg::CELL_BITS] = slid[i] + 1'b1;
                    skip = 1'b1;
                end else begin
                    line_out[k*game_pkg::CELL_BITS +: game_pkg::CELL_BITS] = slid[i];
                end
                k++;
            end
        end
        return line_out;
    endfunction

    assign cur_line    = work_board[line_idx*$bits(game_pkg::line_t) +: $bits(game_pkg::line_t)];
    assign merged_line = merge_line(cur_line);

    always_ff @(posedge clk) begin
        if (reset) begin
            movable <= 1'b0;
        end else if (load) begin
            movable <= 1'b0;
        end else if (step && (merged_line != cur_line)) begin
            movable <= 1'b1;
        end
    end

    // one line replaced per step
    always_ff @(posedge clk) begin
        if (load) begin
            work_board <= rotated;
        end else if (step) begin
            work_board[line_idx*$bits(game_pkg::line_t) +: $bits(game_pkg::line_t)] <=
                merged_line;
        end
    end

endmodule

// ==== verilog/move_counter.sv ====
`timescale 1ns/1ns

module move_counter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   step,
    input  logic                   store,
    input  logic                   movable,
    output game_pkg::line_idx_t    line_idx,
    output logic                   last_line,
    output game_pkg::move_count_t  move_count
);

    always_ff @(posedge clk) begin
        if (reset) begin
            line_idx   <= '0;
            move_count <= '0;
        end else begin
            if (load) begin
                line_idx <= '0;
            end else if (step) begin
                line_idx <= line_idx + 1'b1;
            end
            // only moves that changed the board count
            if (store && movable) begin
                move_count <= move_count + 1'b1;
            end
        end
    end

    assign last_line = (line_idx == game_pkg::line_idx_t'(game_pkg::NUM_LINES - 1));

endmodule

// ==== verilog/move_fsm.sv ====
`timescale 1ns/1ns

module move_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last_line,
    output logic busy,
    output logic load,
    output logic step,
    output logic store
);

    game_pkg::move_state_t state;
    game_pkg::move_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= game_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // load 1, merge 4 (one per line), store 1
    always_comb begin
        state_next = state;
        case (state)
            game_pkg::IDLE: begin
                if (start) begin
                    state_next = game_pkg::LOAD;
                end
            end
            game_pkg::LOAD: begin
                state_next = game_pkg::MERGE;
            end
            game_pkg::MERGE: begin
                if (last_line) begin
                    state_next = game_pkg::STORE;
                end
            end
            default: begin
                state_next = game_pkg::IDLE;
            end
        endcase
    end

    assign busy  = (state != game_pkg::IDLE);
    assign load  = (state == game_pkg::LOAD);
    assign step  = (state == game_pkg::MERGE);
    assign store = (state == game_pkg::STORE);

endmodule

// ==== verilog/tile_spawn.sv ====
`timescale 1ns/1ns

module tile_spawn (
    input  game_pkg::board_t board_in,
    input  game_pkg::pos_t   pos,
    input  game_pkg::prob_t  prob,
    input  logic             movable,
    output game_pkg::board_t new_board,
    output logic             spawned
);

    game_pkg::cell_t target;

    assign target = board_in[pos*game_pkg::CELL_BITS +: game_pkg::CELL_BITS];

    // occupied cell or no move leaves the board as is
    always_comb begin
        new_board = board_in;
        spawned   = 1'b0;
        if (movable && (target == '0)) begin
            if (prob == '0) begin
                new_board[pos*game_pkg::CELL_BITS +: game_pkg::CELL_BITS] =
                    game_pkg::SPAWN_FOUR;
            end else begin
                new_board[pos*game_pkg::CELL_BITS +: game_pkg::CELL_BITS] =
                    game_pkg::SPAWN_TWO;
            end
            spawned = 1'b1;
        end
    end

endmodule
